/* common/sr_params.svh */
`ifndef SR_PARAMS_SVH
`define SR_PARAMS_SVH

// Colour channels per input pixel
`define SR_IN_CH 3

// Convolution outputs for 3 colours x 4 subpixels
`define SR_OUT_CH 12

`define SR_TAPS 9       // 3x3 kernel
`define SR_SCALE 2
`define SR_SUBPIX 4     // SR_SCALE squared

// Parallel MAC lanes that must divide SR_OUT_CH
`define SR_LANES 4
`define SR_GROUPS 3     // SR_OUT_CH / SR_LANES

// Coefficient memory layout
`define SR_BIAS_BASE 324
`define SR_COEF_DEPTH 336

// Room for 27 signed 17-bit products
`define SR_ACC_W 22

`endif

/* common/sr_pixel_pkg.sv */
`include "sr_params.svh"

package sr_pixel_pkg;

    typedef logic [7:0] chan_t;
    typedef logic [23:0] pixel_t;            // R in [23:16], G, then B
    typedef logic signed [7:0] coef_t;
    typedef logic signed [`SR_ACC_W-1:0] acc_t;

    // Channel 0 is R
    function automatic chan_t chan_of(input pixel_t p, input int ic);
        return p[23-8*ic -: 8];
    endfunction

    // Saturate a biased sum to the 0..255 range
    function automatic chan_t clamp_chan(input logic signed [`SR_ACC_W:0] v);
        if (v < 0) begin
            return '0;
        end
        if (v > 255) begin
            return 8'hff;
        end
        return v[7:0];
    endfunction

endpackage

/* common/sr_ctrl_pkg.sv */
`include "sr_params.svh"

package sr_ctrl_pkg;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        RUN   = 2'd1,
        FLUSH = 2'd2
    } seq_state_e;

    typedef logic [$clog2(`SR_COEF_DEPTH)-1:0] coef_addr_t;

    // Weights ordered by output channel, input channel, then tap
    function automatic coef_addr_t weight_addr(input int oc, input int ic, input int tap);
        return coef_addr_t'((oc * `SR_IN_CH + ic) * `SR_TAPS + tap);
    endfunction

    function automatic coef_addr_t bias_addr(input int oc);
        return coef_addr_t'(`SR_BIAS_BASE + oc);
    endfunction

endpackage

/* mac_array/mac_lane.sv */
`timescale 1ns/1ps

module mac_lane (
    input  logic                clk,
    input  logic                rst_n,
    input  sr_pixel_pkg::chan_t pixel_op,
    input  sr_pixel_pkg::coef_t weight,
    input  logic                acc_clear,
    input  logic                acc_en,
    input  logic                group_last,
    output sr_pixel_pkg::acc_t  acc,
    output logic                acc_valid
);

    sr_pixel_pkg::acc_t prod;

    // Pixel is unsigned, so widen with a zero before the signed multiply
    assign prod = $signed({1'b0, pixel_op}) * weight;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc <= '0;
        end else if (acc_en) begin
            if (acc_clear) begin
                acc <= prod;        // First tap of a new group
            end else begin
                acc <= acc + prod;
            end
        end
    end

    // Sum is complete the cycle after the last operand
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_valid <= 1'b0;
        end else begin
            acc_valid <= group_last;
        end
    end

endmodule

/* mac_array/mac_sequencer.sv */
`timescale 1ns/1ps
`include "sr_params.svh"

module mac_sequencer (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    start,
    input  sr_pixel_pkg::pixel_t [8:0]              window,
    input  logic                                    done,
    output logic                                    busy,
    output sr_pixel_pkg::chan_t                     pixel_op,
    output sr_ctrl_pkg::coef_addr_t [`SR_LANES-1:0] rd_addr,
    output logic                                    acc_clear,
    output logic                                    acc_en,
    output logic                                    group_last,
    output logic [1:0]                              group
);

    localparam int LAST_TAP   = `SR_TAPS - 1;
    localparam int LAST_IC    = `SR_IN_CH - 1;
    localparam int LAST_GROUP = `SR_GROUPS - 1;

    sr_ctrl_pkg::seq_state_e state;
    logic [1:0] grp;
    logic [1:0] ic;
    logic [3:0] tap;
    logic       accept;

    assign accept = start && !busy;   // Starts while busy are dropped

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= sr_ctrl_pkg::IDLE;
            grp   <= '0;
            ic    <= '0;
            tap   <= '0;
            busy  <= 1'b0;
        end else begin
            // Busy holds until the shuffle stage reports the last subpixel
            if (done) begin
                busy <= 1'b0;
            end else if (accept) begin
                busy <= 1'b1;
            end

            case (state)
                sr_ctrl_pkg::IDLE: begin
                    grp <= '0;
                    ic  <= '0;
                    tap <= '0;
                    if (accept) begin
                        state <= sr_ctrl_pkg::RUN;
                    end
                end
                sr_ctrl_pkg::RUN: begin
                    if (tap == 4'(LAST_TAP)) begin
                        tap <= '0;
                        if (ic == 2'(LAST_IC)) begin
                            ic <= '0;
                            if (grp == 2'(LAST_GROUP)) begin
                                grp   <= '0;
                                state <= sr_ctrl_pkg::FLUSH;
                            end else begin
                                grp <= grp + 2'd1;
                            end
                        end else begin
                            ic <= ic + 2'd1;
                        end
                    end else begin
                        tap <= tap + 4'd1;
                    end
                end
                sr_ctrl_pkg::FLUSH: state <= sr_ctrl_pkg::IDLE;  // Lanes drain the last group
                default: state <= sr_ctrl_pkg::IDLE;
            endcase
        end
    end

    assign acc_en     = (state == sr_ctrl_pkg::RUN);
    assign acc_clear  = acc_en && (ic == '0) && (tap == '0);
    assign group_last = acc_en && (ic == 2'(LAST_IC)) && (tap == 4'(LAST_TAP));
    assign group      = grp;

    assign pixel_op = sr_pixel_pkg::chan_of(window[tap], int'(ic));

    // Lane j works on output channel grp*SR_LANES+j
    always_comb begin
        for (int j = 0; j < `SR_LANES; j++) begin
            rd_addr[j] = sr_ctrl_pkg::weight_addr(int'(grp) * `SR_LANES + j,
                                                  int'(ic), int'(tap));
        end
    end

endmodule

/* design/coef_store.sv */
`timescale 1ns/1ps
`include "sr_params.svh"

module coef_store (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    wr,
    input  sr_ctrl_pkg::coef_addr_t                 wr_addr,
    input  sr_pixel_pkg::coef_t                     wr_data,
    input  sr_ctrl_pkg::coef_addr_t [`SR_LANES-1:0] rd_addr,
    output sr_pixel_pkg::coef_t [`SR_LANES-1:0]     rd_weight,
    output sr_pixel_pkg::coef_t [`SR_OUT_CH-1:0]    bias
);

    // Weights first, biases from SR_BIAS_BASE up
    sr_pixel_pkg::coef_t mem [`SR_COEF_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SR_COEF_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr && (wr_addr < `SR_COEF_DEPTH)) begin  // Out-of-range writes dropped
            mem[wr_addr] <= wr_data;
        end
    end

    // Per-lane weight reads
    always_comb begin
        for (int j = 0; j < `SR_LANES; j++) begin
            rd_weight[j] = mem[rd_addr[j]];
        end
    end

    // All biases stay visible to the shuffle stage
    always_comb begin
        for (int oc = 0; oc < `SR_OUT_CH; oc++) begin
            bias[oc] = mem[sr_ctrl_pkg::bias_addr(oc)];
        end
    end

endmodule

/* design/shuffle_out.sv */
`timescale 1ns/1ps
`include "sr_params.svh"

module shuffle_out (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  sr_pixel_pkg::acc_t [`SR_LANES-1:0]   acc,
    input  logic [`SR_LANES-1:0]                 acc_valid,
    input  logic [1:0]                           group,
    input  sr_pixel_pkg::coef_t [`SR_OUT_CH-1:0] bias,
    output logic                                 sub_valid,
    output sr_pixel_pkg::pixel_t                 sub_pixel,
    output logic [1:0]                           sub_index,
    output logic                                 done
);

    localparam int LAST_GROUP = `SR_GROUPS - 1;

    sr_pixel_pkg::chan_t chan [`SR_OUT_CH];
    logic signed [`SR_ACC_W:0] biased [`SR_LANES];
    logic [1:0] group_q;       // Lags by one to line up with acc_valid
    logic       emit_active;
    logic [1:0] emit_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            group_q <= '0;
        end else begin
            group_q <= group;
        end
    end

    always_comb begin
        for (int j = 0; j < `SR_LANES; j++) begin
            biased[j] = $signed(acc[j])
                      + $signed(bias[int'(group_q) * `SR_LANES + j]);
        end
    end

    // Lane j of group g fills channel g*SR_LANES+j
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int oc = 0; oc < `SR_OUT_CH; oc++) begin
                chan[oc] <= '0;
            end
        end else begin
            for (int j = 0; j < `SR_LANES; j++) begin
                if (acc_valid[j]) begin
                    chan[int'(group_q) * `SR_LANES + j] <=
                        sr_pixel_pkg::clamp_chan(biased[j]);
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            emit_active <= 1'b0;
            emit_idx    <= '0;
        end else if (acc_valid[0] && (group_q == 2'(LAST_GROUP))) begin
            emit_active <= 1'b1;    // All 12 channels now captured
            emit_idx    <= '0;
        end else if (emit_active) begin
            emit_idx <= emit_idx + 2'd1;
            if (emit_idx == 2'(`SR_SUBPIX - 1)) begin
                emit_active <= 1'b0;
            end
        end
    end

    // Channel c*4+s is colour c of subpixel s
    assign sub_pixel = {chan[0 * `SR_SUBPIX + int'(emit_idx)],
                        chan[1 * `SR_SUBPIX + int'(emit_idx)],
                        chan[2 * `SR_SUBPIX + int'(emit_idx)]};
    assign sub_valid = emit_active;
    assign sub_index = emit_idx;
    assign done      = emit_active && (emit_idx == 2'(`SR_SUBPIX - 1));

endmodule

/* design/sr_upscaler.sv */
`timescale 1ns/1ps
`include "sr_params.svh"

module sr_upscaler (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 coef_wr,
    input  sr_ctrl_pkg::coef_addr_t              coef_addr,
    input  sr_pixel_pkg::coef_t                  coef_data,
    input  logic                                 start,
    input  sr_pixel_pkg::pixel_t [8:0]           window,
    output logic                                 busy,
    output logic                                 sub_valid,
    output sr_pixel_pkg::pixel_t                 sub_pixel,
    output logic [1:0]                           sub_index,
    output logic                                 done
);

    sr_ctrl_pkg::coef_addr_t [`SR_LANES-1:0] rd_addr;
    sr_pixel_pkg::coef_t [`SR_LANES-1:0]     rd_weight;
    sr_pixel_pkg::coef_t [`SR_OUT_CH-1:0]    bias;
    sr_pixel_pkg::chan_t                     pixel_op;
    sr_pixel_pkg::acc_t [`SR_LANES-1:0]      acc;
    logic [`SR_LANES-1:0]                    acc_valid;
    logic                                    acc_clear;
    logic                                    acc_en;
    logic                                    group_last;
    logic [1:0]                              group;

    coef_store u_coef_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (coef_wr),
        .wr_addr   (coef_addr),
        .wr_data   (coef_data),
        .rd_addr   (rd_addr),
        .rd_weight (rd_weight),
        .bias      (bias)
    );

    mac_sequencer u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .window     (window),
        .done       (done),
        .busy       (busy),
        .pixel_op   (pixel_op),
        .rd_addr    (rd_addr),
        .acc_clear  (acc_clear),
        .acc_en     (acc_en),
        .group_last (group_last),
        .group      (group)
    );

    // One lane per output channel within a group
    for (genvar j = 0; j < `SR_LANES; j++) begin : g_lane
        mac_lane u_lane (
            .clk        (clk),
            .rst_n      (rst_n),
            .pixel_op   (pixel_op),
            .weight     (rd_weight[j]),
            .acc_clear  (acc_clear),
            .acc_en     (acc_en),
            .group_last (group_last),
            .acc        (acc[j]),
            .acc_valid  (acc_valid[j])
        );
    end

    shuffle_out u_shuffle (
        .clk       (clk),
        .rst_n     (rst_n),
        .acc       (acc),
        .acc_valid (acc_valid),
        .group     (group),
        .bias      (bias),
        .sub_valid (sub_valid),
        .sub_pixel (sub_pixel),
        .sub_index (sub_index),
        .done      (done)
    );

endmodule

/* verification/sr_upscaler_chk.sv */
`timescale 1ns/1ps
`include "sr_params.svh"

module sr_upscaler_chk (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         coef_wr,
    input sr_ctrl_pkg::coef_addr_t      coef_addr,
    input sr_pixel_pkg::coef_t          coef_data,
    input logic                         start,
    input sr_pixel_pkg::pixel_t [8:0]   window,
    input logic                         busy,
    input logic                         sub_valid,
    input sr_pixel_pkg::pixel_t         sub_pixel,
    input logic [1:0]                   sub_index,
    input logic                         done
);

    sr_pixel_pkg::coef_t  coef_mirror [`SR_COEF_DEPTH];
    sr_pixel_pkg::pixel_t exp_pixel;
    logic [1:0]           exp_idx;
    logic                 started;
    logic                 pending;     // Accepted start without its done yet
    int                   fail_count = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `SR_COEF_DEPTH; i++) begin
                coef_mirror[i] <= '0;
            end
            exp_idx <= '0;
            started <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (coef_wr && (int'(coef_addr) < `SR_COEF_DEPTH)) begin
                coef_mirror[coef_addr] <= coef_data;
            end
            if (sub_valid) begin
                exp_idx <= exp_idx + 2'd1;
            end
            if (start) begin
                started <= 1'b1;
            end
            if (done) begin
                pending <= 1'b0;
            end else if (start && !busy) begin
                pending <= 1'b1;
            end
        end
    end

    // Colour c of subpixel s comes from channel c*4+s
    function automatic sr_pixel_pkg::pixel_t model_subpixel(input logic [1:0] s);
        sr_pixel_pkg::pixel_t px;
        int oc;
        int sum;
        px = '0;
        for (int c = 0; c < `SR_IN_CH; c++) begin
            oc  = c * `SR_SUBPIX + int'(s);
            sum = int'(coef_mirror[`SR_BIAS_BASE + oc]);
            for (int ic = 0; ic < `SR_IN_CH; ic++) begin
                for (int k = 0; k < `SR_TAPS; k++) begin
                    sum += int'(window[k][23 - 8 * ic -: 8])
                         * int'(coef_mirror[(oc * `SR_IN_CH + ic) * `SR_TAPS + k]);
                end
            end
            if (sum < 0) begin
                px[23 - 8 * c -: 8] = 8'h00;
            end else if (sum > 255) begin
                px[23 - 8 * c -: 8] = 8'hff;
            end else begin
                px[23 - 8 * c -: 8] = sum[7:0];
            end
        end
        return px;
    endfunction

    always_comb begin
        exp_pixel = model_subpixel(sub_index);
    end

    a_value: assert property (@(posedge clk) disable iff (!rst_n)
        sub_valid |-> (sub_pixel == exp_pixel))
        else begin
            fail_count++;
            $error("mismatch at %0t: sub_pixel got %h expected %h", $time, sub_pixel, exp_pixel);
        end

    a_index: assert property (@(posedge clk) disable iff (!rst_n)
        sub_valid |-> (sub_index == exp_idx))
        else begin
            fail_count++;
            $error("mismatch at %0t: sub_index got %0d expected %0d", $time, sub_index, exp_idx);
        end

    // Done belongs to the fourth counted subpixel
    a_done: assert property (@(posedge clk) disable iff (!rst_n)
        done == (sub_valid && (exp_idx == 2'd3)))
        else begin
            fail_count++;
            $error("mismatch at %0t: done got %b expected %b", $time, done,
                   sub_valid && (exp_idx == 2'd3));
        end

    a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> (!busy && !sub_valid && !done))
        else begin
            fail_count++;
            $error("outputs active at %0t before the first start", $time);
        end

    a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
        (start && !busy) |=> busy)
        else begin
            fail_count++;
            $error("busy did not rise at %0t after an accepted start", $time);
        end

    // A start seen while busy must not produce a second run
    a_one_run: assert property (@(posedge clk) disable iff (!rst_n)
        sub_valid |-> pending)
        else begin
            fail_count++;
            $error("subpixel at %0t without a pending start", $time);
        end

endmodule

bind sr_upscaler sr_upscaler_chk u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .coef_wr   (coef_wr),
    .coef_addr (coef_addr),
    .coef_data (coef_data),
    .start     (start),
    .window    (window),
    .busy      (busy),
    .sub_valid (sub_valid),
    .sub_pixel (sub_pixel),
    .sub_index (sub_index),
    .done      (done)
);

/* verification/sr_upscaler_tb.sv */
`timescale 1ns/1ps
`include "sr_params.svh"

module sr_upscaler_tb;

    localparam int CLK_PERIOD  = 100;
    localparam int RANDOM_RUNS = 30;
    localparam int RUNS        = RANDOM_RUNS + 2;
    localparam int RUN_LIMIT   = 200;    // Cycles allowed from start to done

    logic                       clk;
    logic                       rst_n;
    logic                       coef_wr;
    sr_ctrl_pkg::coef_addr_t    coef_addr;
    sr_pixel_pkg::coef_t        coef_data;
    logic                       start;
    sr_pixel_pkg::pixel_t [8:0] window;
    logic                       busy;
    logic                       sub_valid;
    sr_pixel_pkg::pixel_t       sub_pixel;
    logic [1:0]                 sub_index;
    logic                       done;
    logic [31:0]                lcg_state;

    sr_upscaler u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .coef_wr   (coef_wr),
        .coef_addr (coef_addr),
        .coef_data (coef_data),
        .start     (start),
        .window    (window),
        .busy      (busy),
        .sub_valid (sub_valid),
        .sub_pixel (sub_pixel),
        .sub_index (sub_index),
        .done      (done)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_byte(output logic [7:0] b);
        lcg_state = lcg_step(lcg_state);
        b = lcg_state[23:16];       // Upper bits are the better mixed ones
    endtask

    task automatic write_coef(input int addr, input logic [7:0] data);
        @(posedge clk);
        coef_wr   <= 1'b1;
        coef_addr <= 9'(addr);
        coef_data <= data;
    endtask

    task automatic end_writes();
        @(posedge clk);
        coef_wr <= 1'b0;
    endtask

    task automatic load_random_coefs();
        logic [7:0] b;
        for (int a = 0; a < `SR_COEF_DEPTH; a++) begin
            next_byte(b);
            write_coef(a, b);
        end
        end_writes();
    endtask

    task automatic load_fixed_coefs(input logic [7:0] w, input logic [7:0] bias);
        for (int a = 0; a < `SR_COEF_DEPTH; a++) begin
            write_coef(a, (a < `SR_BIAS_BASE) ? w : bias);
        end
        end_writes();
    endtask

    task automatic random_window();
        logic [7:0] b;
        for (int k = 0; k < `SR_TAPS; k++) begin
            for (int c = 0; c < `SR_IN_CH; c++) begin
                next_byte(b);
                window[k][8 * c +: 8] <= b;
            end
        end
    endtask

    task automatic run_pixel(input logic poke_busy);
        int cycles;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        if (poke_busy) begin
            repeat (10) @(posedge clk);
            start <= 1'b1;          // Core is mid-run here
            @(posedge clk);
            start <= 1'b0;
        end
        cycles = 0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > RUN_LIMIT) begin
                $display("*** FAILED ***");
                $fatal(1, "done did not arrive within %0d cycles of start", RUN_LIMIT);
            end
        end
        while (busy) begin
            @(negedge clk);
            cycles++;
            if (cycles > RUN_LIMIT) begin
                $display("*** FAILED ***");
                $fatal(1, "busy stayed high after done");
            end
        end
    endtask

    // Stop at the first failed checker assertion
    always @(negedge clk) begin
        if (u_dut.u_chk.fail_count != 0) begin
            $display("*** FAILED ***");
            $fatal(1, "checker assertion failed");
        end
    end

    initial begin
        #((RUNS * (`SR_COEF_DEPTH + 100) + 50) * CLK_PERIOD);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired before all runs finished");
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        coef_wr   = 1'b0;
        coef_addr = '0;
        coef_data = '0;
        start     = 1'b0;
        window    = '0;
        lcg_state = 32'hb2c3;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        for (int r = 0; r < RANDOM_RUNS; r++) begin
            load_random_coefs();
            random_window();
            run_pixel(r % 5 == 1);
        end

        // White window against both ends of the weight range
        load_fixed_coefs(8'h7f, 8'h7f);
        window <= '1;
        run_pixel(1'b0);
        load_fixed_coefs(8'h80, 8'h80);
        run_pixel(1'b0);

        repeat (5) @(posedge clk);
        if (u_dut.u_chk.fail_count == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("*** FAILED ***");
            $fatal(1, "checker reported %0d failures", u_dut.u_chk.fail_count);
        end
    end

endmodule

/* sr_upscaler.f */
+incdir+common
common/sr_pixel_pkg.sv
common/sr_ctrl_pkg.sv
mac_array/mac_lane.sv
mac_array/mac_sequencer.sv
design/coef_store.sv
design/shuffle_out.sv
design/sr_upscaler.sv
verification/sr_upscaler_chk.sv
verification/sr_upscaler_tb.sv

/* Makefile */
SIM  := obj_dir/Vsr_upscaler_tb
SRCS := $(wildcard common/*.sv common/*.svh design/*.sv mac_array/*.sv verification/*.sv)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) sr_upscaler.f
	verilator --binary --timing --assert --top-module sr_upscaler_tb -f sr_upscaler.f

# Checker errors are counted so that the testbench itself ends the run
run: $(SIM)
	./$(SIM) +verilator+error+limit+1000

clean:
	rm -rf obj_dir
